// File: src/masku_pkg.sv
// Shared mask unit types; lane word fixed at 64 bits, at most MaxBeats beats of up to 16 lanes
package masku_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Width of one lane word
  localparam int unsigned ElenBits = 64;
  // Lane count used when the top level does not override it
  localparam int unsigned NrLanesDefault = 4;
  // Beats per instruction, also the words per vector register
  localparam int unsigned MaxBeats = 4;
  // Widest lane count the vl field must cover
  localparam int unsigned MaxLanes = 16;

  // Bits of a beat index
  localparam int unsigned BeatBits = $clog2(MaxBeats);
  // vl must hold MaxBeats * MaxLanes * ElenBits itself, hence the extra bit
  localparam int unsigned VlenBits = $clog2(MaxBeats * MaxLanes * ElenBits) + 1;
  localparam int unsigned VregBits = 5;
  // VRF word address is vd * MaxBeats + beat
  localparam int unsigned VaddrBits = VregBits + BeatBits;

  ////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////

  typedef logic [ElenBits-1:0]  elen_t;
  typedef logic [2:0]           vid_t;
  typedef logic [VlenBits-1:0]  vlen_t;
  typedef logic [VregBits-1:0]  vreg_t;
  typedef logic [VaddrBits-1:0] vaddr_t;
  typedef logic [BeatBits-1:0]  beat_t;

  ////////////////////////////////////////////////////////////
  // Structures
  ////////////////////////////////////////////////////////////

  // Instruction from the sequencer
  typedef struct packed {
    vid_t  id;
    // Vector length in bits
    vlen_t vl;
    vreg_t vd;
    // High means unmasked
    logic  vm;
  } masku_req_t;

  // One queued write towards a lane
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
  } masku_result_t;

endpackage

// File: src/masku_operand_if.sv
// Lane operand bundle; each lane sends a, b and m words, a beat takes all lanes in one cycle
`timescale 1ns/10ps

interface masku_operand_if #(
  parameter int unsigned NrLanes = masku_pkg::NrLanesDefault
) ();
  import masku_pkg::*;

  // Operand a, the ALU result
  elen_t [NrLanes-1:0] a;
  logic  [NrLanes-1:0] a_valid;
  logic  [NrLanes-1:0] a_ready;

  // Operand b, old value of the destination
  elen_t [NrLanes-1:0] b;
  logic  [NrLanes-1:0] b_valid;
  logic  [NrLanes-1:0] b_ready;

  // Operand m, the mask bits
  elen_t [NrLanes-1:0] m;
  logic  [NrLanes-1:0] m_valid;
  logic  [NrLanes-1:0] m_ready;

  // Handshake side, owned by the instruction controller
  modport ctrl (input a_valid, b_valid, m_valid, output a_ready, b_ready, m_ready);
  // Data side, read by the merge ALU
  modport alu (input a, b, m);
  // Lane side, driven from the top-level ports
  modport lanes (
    output a, b, m, a_valid, b_valid, m_valid,
    input  a_ready, b_ready, m_ready
  );

endinterface

// File: src/masku_insn_ctrl.sv
// Holds one instruction at a time; beats past MaxBeats are not issued, vl of 0 still runs one beat
`timescale 1ns/10ps

module masku_insn_ctrl #(
  parameter int unsigned NrLanes = masku_pkg::NrLanesDefault
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Sequencer side
  input  masku_pkg::masku_req_t  req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  // Lane operand handshakes
  masku_operand_if.ctrl          opnd,
  // Current instruction and beat for the merge ALU
  output masku_pkg::masku_req_t  insn_o,
  output masku_pkg::beat_t       beat_o,
  // Result queue side
  output logic                   push_o,
  output masku_pkg::vaddr_t      push_addr_o,
  input  logic                   full_i,
  input  logic                   retire_i,
  // Completion
  output logic                   done_valid_o,
  output masku_pkg::vid_t        done_id_o
);
  import masku_pkg::*;

  // Bits covered by one beat over all lanes
  localparam int unsigned BeatWidth = NrLanes * ElenBits;

  // Counts run from 0 to MaxBeats inclusive
  typedef logic [BeatBits:0] cnt_t;

  ////////////////////////////////////////////////////////////
  // Instruction slot
  ////////////////////////////////////////////////////////////

  masku_req_t insn_q;
  logic       insn_valid_q;
  cnt_t       issue_cnt_q;
  cnt_t       commit_cnt_q;
  logic       done_valid_q;
  vid_t       done_id_q;

  logic       accept;
  logic       fire;
  logic       last_retire;
  vlen_t      beats_raw;
  cnt_t       beats_total;

  // Free slot means we can take the next instruction
  assign req_ready_o = !insn_valid_q;
  assign accept      = req_valid_i && req_ready_o;

  // Beat total, rounded up and clamped to 1..MaxBeats
  always_comb begin
    beats_raw = (insn_q.vl + vlen_t'(BeatWidth - 1)) / vlen_t'(BeatWidth);
    if (beats_raw == '0) begin
      beats_total = cnt_t'(1);
    end else if (beats_raw > vlen_t'(MaxBeats)) begin
      beats_total = cnt_t'(MaxBeats);
    end else begin
      beats_total = cnt_t'(beats_raw);
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand acceptance
  ////////////////////////////////////////////////////////////

  // All lanes together, mask only when vm is low, and room in the queue
  assign fire = insn_valid_q && (issue_cnt_q < beats_total) && !full_i &&
                (&opnd.a_valid) && (&opnd.b_valid) &&
                (insn_q.vm || (&opnd.m_valid));

  assign opnd.a_ready = {NrLanes{fire}};
  assign opnd.b_ready = {NrLanes{fire}};
  // Unmasked instructions leave the mask words alone
  assign opnd.m_ready = {NrLanes{fire && !insn_q.vm}};

  assign insn_o      = insn_q;
  assign beat_o      = issue_cnt_q[BeatBits-1:0];
  assign push_o      = fire;
  assign push_addr_o = vaddr_t'(insn_q.vd) * vaddr_t'(MaxBeats) + vaddr_t'(beat_o);

  // Final beat leaves the queue in this cycle
  assign last_retire = retire_i && (commit_cnt_q == beats_total - cnt_t'(1));

  ////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_valid_q <= 1'b0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_valid_q <= 1'b0;
    end else begin
      done_valid_q <= last_retire;
      if (accept) begin
        insn_valid_q <= 1'b1;
        issue_cnt_q  <= '0;
        commit_cnt_q <= '0;
      end else begin
        if (fire) begin
          issue_cnt_q <= issue_cnt_q + cnt_t'(1);
        end
        if (retire_i) begin
          commit_cnt_q <= commit_cnt_q + cnt_t'(1);
        end
        // Slot frees together with the done pulse
        if (last_retire) begin
          insn_valid_q <= 1'b0;
        end
      end
    end
  end

  // Held instruction and id of the finished one
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= req_i;
    end
    if (last_retire) begin
      done_id_q <= insn_q.id;
    end
  end

  assign done_valid_o = done_valid_q;
  assign done_id_o    = done_id_q;

endmodule

// File: src/masku_merge_alu.sv
// Purely combinational bit merge; lane l owns bits l*64 to l*64+63 of the beat word
`timescale 1ns/10ps

module masku_merge_alu #(
  parameter int unsigned NrLanes = masku_pkg::NrLanesDefault
) (
  input  masku_pkg::masku_req_t               insn_i,
  input  masku_pkg::beat_t                    beat_i,
  masku_operand_if.alu                        opnd,
  output masku_pkg::elen_t      [NrLanes-1:0] wdata_o
);
  import masku_pkg::*;

  localparam int unsigned BeatWidth = NrLanes * ElenBits;

  // First global bit index of this beat
  vlen_t beat_base;
  // Body bits still left at the start of the beat
  vlen_t body_left;
  // Enable per lane, body and mask combined
  elen_t [NrLanes-1:0] bit_en;

  ////////////////////////////////////////////////////////////
  // Bit enables
  ////////////////////////////////////////////////////////////

  always_comb begin
    beat_base = vlen_t'(beat_i) * vlen_t'(BeatWidth);
    // Tail beats past vl get no body bits
    body_left = (insn_i.vl > beat_base) ? (insn_i.vl - beat_base) : '0;

    for (int l = 0; l < NrLanes; l++) begin
      for (int i = 0; i < ElenBits; i++) begin
        // Global index below vl
        bit_en[l][i] = vlen_t'(l * ElenBits + i) < body_left;
      end
      // Masked instructions also need the matching m bit
      if (!insn_i.vm) begin
        bit_en[l] = bit_en[l] & opnd.m[l];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Merge
  ////////////////////////////////////////////////////////////

  // Enabled bits take a, others keep the old destination b
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      wdata_o[l] = (opnd.a[l] & bit_en[l]) | (opnd.b[l] & ~bit_en[l]);
    end
  end

endmodule

// File: src/masku_result_queue.sv
// Two beats deep; push must not come while full_o is high, every lane gets its own req/gnt
`timescale 1ns/10ps

module masku_result_queue #(
  parameter int unsigned NrLanes = masku_pkg::NrLanesDefault
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Write side from the controller and the merge ALU
  input  logic                                 push_i,
  input  masku_pkg::vaddr_t                    push_addr_i,
  input  masku_pkg::vid_t                      push_id_i,
  input  masku_pkg::elen_t       [NrLanes-1:0] wdata_i,
  output logic                                 full_o,
  output logic                                 retire_o,
  // Write-back to the lanes
  output logic                   [NrLanes-1:0] result_req_o,
  output masku_pkg::vaddr_t      [NrLanes-1:0] result_addr_o,
  output masku_pkg::vid_t        [NrLanes-1:0] result_id_o,
  output masku_pkg::elen_t       [NrLanes-1:0] result_wdata_o,
  input  logic                   [NrLanes-1:0] result_gnt_i
);
  import masku_pkg::*;

  localparam int unsigned Depth   = 2;
  localparam int unsigned PtrBits = $clog2(Depth);

  ////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////

  masku_result_t [Depth-1:0][NrLanes-1:0] entry_q;
  logic          [Depth-1:0][NrLanes-1:0] valid_q;
  logic          [Depth-1:0][NrLanes-1:0] valid_d;
  logic          [PtrBits-1:0]            wr_ptr_q;
  logic          [PtrBits-1:0]            rd_ptr_q;
  // Entries written and not yet retired
  logic          [PtrBits:0]              cnt_q;

  // Lanes of the head entry still waiting after this cycle's grants
  logic          [NrLanes-1:0]            rd_left;
  logic                                   retire;

  assign full_o = (cnt_q == (PtrBits + 1)'(Depth));

  always_comb begin
    valid_d = valid_q;
    // Grant clears the lane's request on this edge
    rd_left           = valid_q[rd_ptr_q] & ~result_gnt_i;
    valid_d[rd_ptr_q] = rd_left;
    // Head retires once no lane still asks
    retire = (cnt_q != '0) && (rd_left == '0);
    // New beat requests on every lane
    if (push_i) begin
      valid_d[wr_ptr_q] = '1;
    end
  end

  assign retire_o = retire;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      // Pointers wrap by width since Depth is a power of two
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (retire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + (PtrBits + 1)'(push_i) - (PtrBits + 1)'(retire);
    end
  end

  // Payload written with the beat
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      for (int l = 0; l < NrLanes; l++) begin
        entry_q[wr_ptr_q][l] <= '{id: push_id_i, addr: push_addr_i, wdata: wdata_i[l]};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Lane outputs
  ////////////////////////////////////////////////////////////

  // Head entry stays stable until its lane is granted
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      result_req_o[l]   = valid_q[rd_ptr_q][l];
      result_addr_o[l]  = entry_q[rd_ptr_q][l].addr;
      result_id_o[l]    = entry_q[rd_ptr_q][l].id;
      result_wdata_o[l] = entry_q[rd_ptr_q][l].wdata;
    end
  end

endmodule

// File: src/masku_top.sv
// Mask unit top; one instruction in flight, whole words written, NrLanes up to 16
`timescale 1ns/10ps

module masku_top #(
  parameter int unsigned NrLanes = masku_pkg::NrLanesDefault
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Sequencer
  input  masku_pkg::masku_req_t               req_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  // Lane operands
  input  masku_pkg::elen_t      [NrLanes-1:0] operand_a_i,
  input  masku_pkg::elen_t      [NrLanes-1:0] operand_b_i,
  input  masku_pkg::elen_t      [NrLanes-1:0] operand_m_i,
  input  logic                  [NrLanes-1:0] operand_a_valid_i,
  input  logic                  [NrLanes-1:0] operand_b_valid_i,
  input  logic                  [NrLanes-1:0] operand_m_valid_i,
  output logic                  [NrLanes-1:0] operand_a_ready_o,
  output logic                  [NrLanes-1:0] operand_b_ready_o,
  output logic                  [NrLanes-1:0] operand_m_ready_o,
  // Lane write-back
  output logic                  [NrLanes-1:0] result_req_o,
  output masku_pkg::vaddr_t     [NrLanes-1:0] result_addr_o,
  output masku_pkg::vid_t       [NrLanes-1:0] result_id_o,
  output masku_pkg::elen_t      [NrLanes-1:0] result_wdata_o,
  input  logic                  [NrLanes-1:0] result_gnt_i,
  // Completion
  output logic                                done_valid_o,
  output masku_pkg::vid_t                     done_id_o
);
  import masku_pkg::*;

  masku_req_t          insn;
  beat_t               beat;
  logic                push;
  vaddr_t              push_addr;
  logic                full;
  logic                retire;
  elen_t [NrLanes-1:0] wdata;

  ////////////////////////////////////////////////////////////
  // Operand bundle
  ////////////////////////////////////////////////////////////

  masku_operand_if #(.NrLanes(NrLanes)) opnd_if ();

  // Lane side of the bundle
  assign opnd_if.a         = operand_a_i;
  assign opnd_if.b         = operand_b_i;
  assign opnd_if.m         = operand_m_i;
  assign opnd_if.a_valid   = operand_a_valid_i;
  assign opnd_if.b_valid   = operand_b_valid_i;
  assign opnd_if.m_valid   = operand_m_valid_i;
  assign operand_a_ready_o = opnd_if.a_ready;
  assign operand_b_ready_o = opnd_if.b_ready;
  assign operand_m_ready_o = opnd_if.m_ready;

  ////////////////////////////////////////////////////////////
  // Submodules
  ////////////////////////////////////////////////////////////

  masku_insn_ctrl #(.NrLanes(NrLanes)) insn_ctrl_i (
    .clk_i,
    .rst_ni,
    .req_i,
    .req_valid_i,
    .req_ready_o,
    .opnd         (opnd_if.ctrl),
    .insn_o       (insn),
    .beat_o       (beat),
    .push_o       (push),
    .push_addr_o  (push_addr),
    .full_i       (full),
    .retire_i     (retire),
    .done_valid_o,
    .done_id_o
  );

  masku_merge_alu #(.NrLanes(NrLanes)) merge_alu_i (
    .insn_i  (insn),
    .beat_i  (beat),
    .opnd    (opnd_if.alu),
    .wdata_o (wdata)
  );

  // Id comes from the held instruction, same for every beat
  masku_result_queue #(.NrLanes(NrLanes)) result_queue_i (
    .clk_i,
    .rst_ni,
    .push_i         (push),
    .push_addr_i    (push_addr),
    .push_id_i      (insn.id),
    .wdata_i        (wdata),
    .full_o         (full),
    .retire_o       (retire),
    .result_req_o,
    .result_addr_o,
    .result_id_o,
    .result_wdata_o,
    .result_gnt_i
  );

endmodule

// File: testbench/tb_masku_tasks.svh
// Directed tests for tb_masku; expected words follow the merge rule bit by bit, 4 lanes assumed
////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_word(input elen_t got, input elen_t exp, input string what);
  if (got !== exp) begin
    err_cnt++;
    $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_addr(input vaddr_t got, input vaddr_t exp, input string what);
  if (got !== exp) begin
    err_cnt++;
    $display("CHECK FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
  end
endtask

task automatic check_id(input vid_t got, input vid_t exp, input string what);
  if (got !== exp) begin
    err_cnt++;
    $display("CHECK FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    err_cnt++;
    $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
  end
endtask

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// Beats per instruction, rounded up, at least one
function automatic int beats_for(input vlen_t vl);
  int n;
  n = (int'(vl) + BeatWidth - 1) / BeatWidth;
  if (n < 1) n = 1;
  if (n > int'(MaxBeats)) n = int'(MaxBeats);
  return n;
endfunction

function automatic elen_t merge_expect(input elen_t a, input elen_t b, input elen_t m,
                                       input vlen_t vl, input logic vm,
                                       input int beat, input int lane);
  elen_t w;
  int    gidx;
  for (int i = 0; i < 64; i++) begin
    gidx = beat * BeatWidth + lane * 64 + i;
    // Body bit, and mask bit too when masked
    w[i] = (gidx < int'(vl) && (vm || m[i])) ? a[i] : b[i];
  end
  return w;
endfunction

////////////////////////////////////////////////////////////
// Background threads
////////////////////////////////////////////////////////////

task automatic drive_grants();
  logic [31:0] r;
  forever begin
    @(posedge clk_i);
    if (!rst_ni || grant_mode == 1) begin
      result_gnt_i <= '0;
    end else if (grant_mode == 2) begin
      // Upper LCG bits since the low ones have short periods
      r = next_rand();
      result_gnt_i <= r[31:32-NrLanes];
    end else begin
      result_gnt_i <= '1;
    end
  end
endtask

// Samples at the falling edge, where outputs are settled
task automatic record_grants();
  forever begin
    @(negedge clk_i);
    if (rst_ni) begin
      for (int l = 0; l < NrLanes; l++) begin
        if (result_req_o[l] && result_gnt_i[l]) begin
          sb_word[result_addr_o[l]][l] = result_wdata_o[l];
          check_id(result_id_o[l], cur_id, "result id");
          if (log_cnt[l] < int'(MaxBeats)) addr_log[l][log_cnt[l]] = result_addr_o[l];
          log_cnt[l]++;
        end
      end
      if (busy && !done_valid_o) check_bit(req_ready_o, 1'b0, "req_ready_o while busy");
      // Two beats queued and no grants
      if (grant_mode == 1 && beats_fed >= 2) begin
        check_bit(|operand_a_ready_o, 1'b0, "operand ready with full queue");
      end
      if (done_valid_o) begin
        done_cnt++;
        done_id_seen = done_id_o;
        busy = 1'b0;
      end
    end
  end
endtask

task automatic watch_timeout();
  while (cycle_cnt < TimeoutCycles) begin
    @(posedge clk_i);
    cycle_cnt++;
  end
  $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
  $display(">>> FAIL");
  $finish;
endtask

////////////////////////////////////////////////////////////
// Stimulus
////////////////////////////////////////////////////////////

// Ends on the accepting clock edge
task automatic issue_request(input masku_req_t req);
  @(posedge clk_i);
  req_i       <= req;
  req_valid_i <= 1'b1;
  do @(negedge clk_i); while (!req_ready_o);
  @(posedge clk_i);
  req_valid_i <= 1'b0;
  busy = 1'b1;
endtask

task automatic feed_operands(input int nbeats, input vlen_t vl, input logic vm);
  elen_t a;
  elen_t b;
  elen_t m;
  for (int bt = 0; bt < nbeats; bt++) begin
    for (int l = 0; l < NrLanes; l++) begin
      a = {next_rand(), next_rand()};
      b = {next_rand(), next_rand()};
      m = {next_rand(), next_rand()};
      operand_a_i[l] <= a;
      operand_b_i[l] <= b;
      operand_m_i[l] <= m;
      exp_word[bt][l] = merge_expect(a, b, m, vl, vm, bt, l);
    end
    operand_a_valid_i <= '1;
    operand_b_valid_i <= '1;
    // Unmasked beats must not wait for the mask
    operand_m_valid_i <= {NrLanes{!vm}};
    do @(negedge clk_i); while (!(&operand_a_ready_o));
    for (int l = 0; l < NrLanes; l++) begin
      check_bit(operand_b_ready_o[l], 1'b1, "b ready at beat");
      check_bit(operand_m_ready_o[l], !vm, "m ready at beat");
    end
    @(posedge clk_i);
    beats_fed++;
  end
  operand_a_valid_i <= '0;
  operand_b_valid_i <= '0;
  operand_m_valid_i <= '0;
endtask

task automatic release_grants(input int hold);
  if (hold > 0) begin
    repeat (hold) @(posedge clk_i);
    grant_mode <= 2;
  end
endtask

task automatic run_instruction(input vid_t id, input int vl, input int vd, input logic vm,
                               input int hold);
  masku_req_t req;
  vaddr_t     addr;
  int         nbeats;
  req.id = id;
  req.vl = vlen_t'(vl);
  req.vd = vreg_t'(vd);
  req.vm = vm;
  nbeats = beats_for(req.vl);
  for (int l = 0; l < NrLanes; l++) log_cnt[l] = 0;
  done_cnt   = 0;
  beats_fed  = 0;
  cur_id     = id;
  grant_mode = (hold > 0) ? 1 : 0;

  issue_request(req);
  fork
    feed_operands(nbeats, req.vl, vm);
    release_grants(hold);
  join
  while (done_cnt == 0) @(negedge clk_i);
  repeat (2) @(negedge clk_i);

  if (done_cnt != 1) begin
    other_cnt++;
    $display("Error: %0d done pulses for id %0d instead of one", done_cnt, id);
  end
  check_id(done_id_seen, id, "done id");
  for (int l = 0; l < NrLanes; l++) begin
    if (log_cnt[l] != nbeats) begin
      other_cnt++;
      $display("Error: lane %0d took %0d writes instead of %0d", l, log_cnt[l], nbeats);
    end
    for (int bt = 0; bt < nbeats; bt++) begin
      addr = vaddr_t'(vd * int'(MaxBeats) + bt);
      check_addr(addr_log[l][bt], addr, "write address order");
      check_word(sb_word[addr][l], exp_word[bt][l], "written word");
    end
  end
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic after_reset_outputs();
  @(negedge clk_i);
  check_bit(req_ready_o, 1'b1, "req_ready_o after reset");
  check_bit(|result_req_o, 1'b0, "result_req_o after reset");
  check_bit(|operand_a_ready_o, 1'b0, "a ready after reset");
  check_bit(|operand_b_ready_o, 1'b0, "b ready after reset");
  check_bit(|operand_m_ready_o, 1'b0, "m ready after reset");
  check_bit(done_valid_o, 1'b0, "done_valid_o after reset");
endtask

task automatic unmasked_full_length();
  run_instruction(3'd1, 1024, 2, 1'b1, 0);
endtask

// Two beats, one beat, and vl of zero
task automatic partial_vl_tails();
  run_instruction(3'd2, 300, 5, 1'b1, 0);
  run_instruction(3'd3, 100, 7, 1'b1, 0);
  run_instruction(3'd4, 0, 9, 1'b1, 0);
endtask

task automatic masked_merge();
  run_instruction(3'd5, 700, 11, 1'b0, 0);
  run_instruction(3'd6, 1024, 31, 1'b0, 0);
endtask

// Held grants first, then a second instruction once done
task automatic back_pressure_grants();
  run_instruction(3'd7, 1024, 20, 1'b0, 20);
  run_instruction(3'd0, 512, 21, 1'b1, 0);
endtask

// File: testbench/tb_masku.sv
// Mask unit testbench for 4 lanes; grant model and monitors run as threads of the main process
`timescale 1ns/10ps

module tb_masku;
  import masku_pkg::*;

  localparam int NrLanes       = 4;
  localparam int BeatWidth     = NrLanes * 64;
  localparam int NrAddr        = 1 << VaddrBits;
  localparam int TimeoutCycles = 4000;

  ////////////////////////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////////////////////////

  logic                 clk_i;
  logic                 rst_ni;
  masku_req_t           req_i;
  logic                 req_valid_i;
  logic                 req_ready_o;
  elen_t  [NrLanes-1:0] operand_a_i;
  elen_t  [NrLanes-1:0] operand_b_i;
  elen_t  [NrLanes-1:0] operand_m_i;
  logic   [NrLanes-1:0] operand_a_valid_i;
  logic   [NrLanes-1:0] operand_b_valid_i;
  logic   [NrLanes-1:0] operand_m_valid_i;
  logic   [NrLanes-1:0] operand_a_ready_o;
  logic   [NrLanes-1:0] operand_b_ready_o;
  logic   [NrLanes-1:0] operand_m_ready_o;
  logic   [NrLanes-1:0] result_req_o;
  vaddr_t [NrLanes-1:0] result_addr_o;
  vid_t   [NrLanes-1:0] result_id_o;
  elen_t  [NrLanes-1:0] result_wdata_o;
  logic   [NrLanes-1:0] result_gnt_i;
  logic                 done_valid_o;
  vid_t                 done_id_o;

  ////////////////////////////////////////////////////////////
  // Testbench state
  ////////////////////////////////////////////////////////////

  logic [31:0] lcg_state;
  int          err_cnt;
  int          other_cnt;
  int          cycle_cnt;
  // Grant mode 0 grants every lane, 1 withholds grants, 2 draws lanes at random
  int          grant_mode;
  int          beats_fed;
  int          done_cnt;
  vid_t        done_id_seen;
  vid_t        cur_id;
  // Instruction accepted and no done seen yet
  logic        busy;

  // Scoreboard of granted words by address and lane
  elen_t       sb_word  [NrAddr][NrLanes];
  // Grant order per lane
  vaddr_t      addr_log [NrLanes][MaxBeats];
  int          log_cnt  [NrLanes];
  // Expected merge result per beat and lane
  elen_t       exp_word [MaxBeats][NrLanes];

  masku_top #(.NrLanes(NrLanes)) masku_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Numerical Recipes constants
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  `include "tb_masku_tasks.svh"

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    lcg_state         = 32'hb01e_8ace;
    err_cnt           = 0;
    other_cnt         = 0;
    cycle_cnt         = 0;
    grant_mode        = 0;
    beats_fed         = 0;
    done_cnt          = 0;
    done_id_seen      = '0;
    cur_id            = '0;
    busy              = 1'b0;
    rst_ni            = 1'b0;
    req_i             = '0;
    req_valid_i       = 1'b0;
    operand_a_i       = '0;
    operand_b_i       = '0;
    operand_m_i       = '0;
    operand_a_valid_i = '0;
    operand_b_valid_i = '0;
    operand_m_valid_i = '0;
    result_gnt_i      = '0;
    for (int l = 0; l < NrLanes; l++) begin
      log_cnt[l] = 0;
    end

    fork
      drive_grants();
      record_grants();
      watch_timeout();
    join_none

    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    after_reset_outputs();
    unmasked_full_length();
    partial_vl_tails();
    masked_merge();
    back_pressure_grants();

    $display("Summary: %0d value errors, %0d other errors", err_cnt, other_cnt);
    if (err_cnt == 0 && other_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+testbench
src/masku_pkg.sv
src/masku_operand_if.sv
src/masku_insn_ctrl.sv
src/masku_merge_alu.sv
src/masku_result_queue.sv
src/masku_top.sv
testbench/tb_masku.sv

// File: Makefile
# Verilator build and run for the mask unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_masku
FILELIST  := verilog.f
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
